// File: build.f
+incdir+logic
logic/lookup_pkg.sv
logic/ctrl_parser.sv
logic/entry_index_counter.sv
logic/tcam_array.sv
logic/action_table.sv
logic/lookup_sequencer.sv
logic/lookup_engine.sv
dv/lookup_checker.sv
dv/lookup_monitor.sv
dv/tb_lookup_engine.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_lookup_engine -f build.f -o sim_lookup

# the log decides the result, so a non-zero exit here must not stop the script
./obj_dir/sim_lookup +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

grep -q "^RESULT: PASS$" sim.log

// File: dv/tb_lookup_engine.sv
`timescale 1ns/10ps
`include "lookup_consts.svh"

module tb_lookup_engine import lookup_pkg::*; ();

    localparam int MIX_OPS = 40;
    // packet lengths count the idle beat after each packet
    localparam int PKT_BEATS = 52 + 19 + 8 * 9 + MIX_OPS * 10;
    localparam int LOOKUPS = 20 + 16 + 40 + 8 + 16 + MIX_OPS;
    localparam int TIMEOUT_CYCLES = (PKT_BEATS + 6 * LOOKUPS) * 2;

    logic         clk = 1'b0;
    logic         rst_n;
    lookup_req_t  req;
    lookup_resp_t resp;
    ctrl_beat_t   ctrl_in;
    ctrl_beat_t   ctrl_out;
    logic [31:0]  rng_state = 32'h2fcd3856;
    key_t         keys [16];
    ctrl_data_t   body [$];
    int           cycle_count = 0;
    int           wait_errors = 0;
    int           reported = 0;
    int           mon_errors;
    int           mon_lookups;
    int           mon_forwarded;

    lookup_engine u_lookup_engine (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .resp     (resp),
        .ctrl_in  (ctrl_in),
        .ctrl_out (ctrl_out)
    );

    lookup_monitor u_monitor (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .resp      (resp),
        .ctrl_in   (ctrl_in),
        .ctrl_out  (ctrl_out),
        .errors    (mon_errors),
        .lookups   (mon_lookups),
        .forwarded (mon_forwarded)
    );

    bind lookup_engine lookup_checker u_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .resp      (resp),
        .ctrl_out  (ctrl_out),
        .cam_we    (cam_we),
        .act_hi_we (act_hi_we),
        .act_we    (act_we)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic ctrl_data_t make_header(input logic [4:0] stage, input logic [2:0] lkid,
                                               input logic [15:0] flag, input logic [3:0] sel,
                                               input logic [3:0] start);
        logic [31:0] r;
        r = next_rand();
        return {flag, stage, lkid, sel, 4'h0, start, r[27:0]};
    endfunction

    // one of stage, lookup id or flag is wrong
    function automatic ctrl_data_t foreign_header(input logic [31:0] r);
        logic [4:0]  stage;
        logic [2:0]  lkid;
        logic [15:0] flag;
        stage = 5'd0;
        lkid  = 3'd2;
        flag  = `LKP_MAGIC;
        case (r[5:4])
            2'd0: stage = 5'd1 + {1'b0, r[11:8]};
            2'd1: lkid = (r[14:12] == 3'd2) ? 3'd3 : r[14:12];
            default: flag = (r[31:16] == `LKP_MAGIC) ? 16'h0 : r[31:16];
        endcase
        return make_header(stage, lkid, flag, {2'b00, r[7:6]}, r[3:0]);
    endfunction

    task automatic send_packet(input ctrl_data_t header);
        int n;
        n = body.size();
        @(negedge clk);
        ctrl_in = '{data: header, valid: 1'b1, last: (n == 0)};
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            ctrl_in = '{data: body[i], valid: 1'b1, last: (i == n - 1)};
        end
        @(negedge clk);
        ctrl_in.valid = 1'b0;
        ctrl_in.last  = 1'b0;
        body.delete();
    endtask

    task automatic run_lookup(input key_t key, input key_t mask);
        logic [31:0] hi;
        logic [31:0] lo;
        int          waited;
        hi = next_rand();
        lo = next_rand();
        @(negedge clk);
        req = '{key: key, mask: mask, phv: {hi, lo}, valid: 1'b1};
        @(negedge clk);
        req.valid = 1'b0;
        waited = 0;
        while (resp.valid !== 1'b1 && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (resp.valid !== 1'b1) begin
            $display("lookup for key %h got no response within 8 cycles", key);
            wait_errors++;
        end
    endtask

    task automatic report_test(input int num, input string name);
        int total;
        repeat (2) @(negedge clk);
        #1;
        total = mon_errors + wait_errors + u_lookup_engine.u_checker.fail_count;
        $display("test %0d %s: %0d errors", num, name, total - reported);
        reported = total;
    endtask

    initial begin
        logic [31:0] r;
        logic [3:0]  idx;
        key_t        flip;
        key_t        mask;
        int          total;
        rst_n   = 1'b0;
        req     = '0;
        ctrl_in = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < 20; i++) begin
            run_lookup(next_rand(), next_rand());
        end
        report_test(1, "misses after reset");

        for (int i = 0; i < 32; i++) begin
            body.push_back({next_rand(), next_rand()});
        end
        send_packet(make_header(5'd0, 3'd2, `LKP_MAGIC, 4'd1, 4'd0));
        for (int i = 0; i < 16; i++) begin
            keys[i] = next_rand();
            body.push_back({next_rand(), keys[i]});
        end
        send_packet(make_header(5'd0, 3'd2, `LKP_MAGIC, 4'd0, 4'd0));
        for (int i = 0; i < 16; i++) begin
            run_lookup(keys[i], '0);
        end
        report_test(2, "exact lookups");

        for (int i = 0; i < 40; i++) begin
            r    = next_rand();
            flip = next_rand() & next_rand() & next_rand();
            mask = next_rand() & next_rand();
            if (r[4]) begin
                mask = mask | flip;
            end
            run_lookup(keys[r[3:0]] ^ flip, mask);
        end
        report_test(3, "masked lookups");

        // entries 14, 15, 0, 1, 2
        for (int i = 0; i < 5; i++) begin
            idx       = 4'd14 + i[3:0];
            keys[idx] = next_rand();
            body.push_back({next_rand(), keys[idx]});
        end
        send_packet(make_header(5'd0, 3'd2, `LKP_MAGIC, 4'd0, 4'd14));
        for (int i = 0; i < 10; i++) begin
            body.push_back({next_rand(), next_rand()});
        end
        send_packet(make_header(5'd0, 3'd2, `LKP_MAGIC, 4'd2, 4'd14));
        for (int i = 0; i < 8; i++) begin
            idx = 4'd14 + i[3:0];
            run_lookup(keys[idx], '0);
        end
        report_test(4, "index wraparound");

        for (int i = 0; i < 8; i++) begin
            r = next_rand();
            for (int j = 0; j < ((i == 0) ? 0 : int'(r[30:28])); j++) begin
                body.push_back({next_rand(), next_rand()});
            end
            send_packet(foreign_header(r));
        end
        for (int i = 0; i < 16; i++) begin
            run_lookup(keys[i], '0);
        end
        report_test(5, "foreign packets");

        for (int i = 0; i < MIX_OPS; i++) begin
            r = next_rand();
            case (r[1:0])
                2'd0: begin
                    for (int j = 0; j <= int'(r[13:12]); j++) begin
                        idx       = r[11:8] + j[3:0];
                        keys[idx] = next_rand();
                        body.push_back({next_rand(), keys[idx]});
                    end
                    send_packet(make_header(5'd0, 3'd2, `LKP_MAGIC, 4'd0, r[11:8]));
                end
                2'd1: begin
                    for (int j = 0; j < 2 * (1 + int'(r[13:12])); j++) begin
                        body.push_back({next_rand(), next_rand()});
                    end
                    send_packet(make_header(5'd0, 3'd2, `LKP_MAGIC,
                                            4'd1 + {1'b0, r[18:16]}, r[11:8]));
                end
                2'd2: begin
                    for (int j = 0; j < int'(r[22:20]); j++) begin
                        body.push_back({next_rand(), next_rand()});
                    end
                    send_packet(foreign_header(next_rand()));
                end
                default: begin
                    flip = next_rand() & next_rand() & next_rand();
                    mask = r[2] ? (next_rand() | flip) : '0;
                    run_lookup(keys[r[7:4]] ^ flip, mask);
                end
            endcase
        end
        report_test(6, "random mix");

        repeat (4) @(negedge clk);
        #1;
        total = mon_errors + wait_errors + u_lookup_engine.u_checker.fail_count;
        $display("lookups %0d, forwarded beats %0d, errors %0d",
                 mon_lookups, mon_forwarded, total);
        if (total == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: dv/lookup_monitor.sv
`timescale 1ns/10ps
`include "lookup_consts.svh"

module lookup_monitor import lookup_pkg::*; #(
    parameter logic [4:0] stage_id  = 5'd0,
    parameter logic [2:0] lookup_id = 3'd2
) (
    input  logic         clk,
    input  logic         rst_n,
    input  lookup_req_t  req,
    input  lookup_resp_t resp,
    input  ctrl_beat_t   ctrl_in,
    input  ctrl_beat_t   ctrl_out,
    output int           errors,
    output int           lookups,
    output int           forwarded
);

    // parser model states
    localparam int P_IDLE = 0;
    localparam int P_PASS = 1;
    localparam int P_CAM  = 2;
    localparam int P_HI   = 3;
    localparam int P_LO   = 4;

    key_t        cam_key [16];
    logic [15:0] cam_valid;
    act_t        act_mem [16];
    logic [15:0] act_known;
    ctrl_data_t  hi_half;
    int          pstate;
    logic [3:0]  cam_ptr;
    logic [3:0]  act_ptr;
    int          cycle;
    int          busy_until;
    int          resp_due = -1;
    act_t        exp_action;
    phv_t        exp_phv;
    logic        exp_unknown;
    ctrl_beat_t  exp_out;
    int          err_count = 0;
    int          lookup_count = 0;
    int          fwd_count = 0;

    assign errors    = err_count;
    assign lookups   = lookup_count;
    assign forwarded = fwd_count;

    function automatic logic for_this_stage(input ctrl_data_t hdr);
        return (hdr[63:48] == `LKP_MAGIC) && (hdr[47:43] == stage_id)
               && (hdr[42:40] == lookup_id);
    endfunction

    task automatic report_mismatch(input string msg);
        $display("mismatch at %0t: %s", $time, msg);
        err_count++;
    endtask

    always @(posedge clk) begin : model
        logic       hit;
        logic [3:0] hit_idx;
        if (!rst_n) begin
            cam_valid  = '0;
            act_known  = '0;
            pstate     = P_IDLE;
            cycle      = 0;
            busy_until = -1;
            resp_due   = -1;
            exp_out    = '0;
        end else begin
            cycle   = cycle + 1;
            exp_out = '0;
            // lookup sees the tables as they were before this edge
            if (req.valid && cycle > busy_until) begin
                hit     = 1'b0;
                hit_idx = '0;
                for (int i = 0; i < 16; i++) begin
                    if (!hit && cam_valid[i]
                        && (cam_key[i] & ~req.mask) == (req.key & ~req.mask)) begin
                        hit     = 1'b1;
                        hit_idx = i[3:0];
                    end
                end
                exp_action  = hit ? act_mem[hit_idx] : act_t'(`LKP_DEFAULT_ACT);
                exp_unknown = hit && !act_known[hit_idx];
                exp_phv     = req.phv;
                resp_due    = cycle + (hit ? 3 : 1);
                busy_until  = resp_due;
            end
            if (ctrl_in.valid) begin
                case (pstate)
                    P_IDLE: begin
                        if (for_this_stage(ctrl_in.data)) begin
                            cam_ptr = ctrl_in.data[31:28];
                            act_ptr = ctrl_in.data[31:28];
                            if (!ctrl_in.last) begin
                                pstate = (ctrl_in.data[39:36] == 4'd0) ? P_CAM : P_HI;
                            end
                        end else begin
                            exp_out = ctrl_in;
                            pstate  = ctrl_in.last ? P_IDLE : P_PASS;
                        end
                    end
                    P_PASS: begin
                        exp_out = ctrl_in;
                        pstate  = ctrl_in.last ? P_IDLE : P_PASS;
                    end
                    P_CAM: begin
                        cam_key[cam_ptr]   = ctrl_in.data[31:0];
                        cam_valid[cam_ptr] = 1'b1;
                        cam_ptr            = cam_ptr + 4'd1;
                        pstate             = ctrl_in.last ? P_IDLE : P_CAM;
                    end
                    P_HI: begin
                        hi_half = ctrl_in.data;
                        pstate  = ctrl_in.last ? P_IDLE : P_LO;
                    end
                    default: begin
                        act_mem[act_ptr]   = {hi_half, ctrl_in.data};
                        act_known[act_ptr] = 1'b1;
                        act_ptr            = act_ptr + 4'd1;
                        pstate             = ctrl_in.last ? P_IDLE : P_HI;
                    end
                endcase
            end
        end
    end

    // outputs compared mid-cycle, away from the clock edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (ctrl_out.valid !== exp_out.valid) begin
                report_mismatch($sformatf("ctrl_out.valid %b, expected %b",
                                          ctrl_out.valid, exp_out.valid));
            end else if (exp_out.valid) begin
                fwd_count++;
                if (ctrl_out.data !== exp_out.data || ctrl_out.last !== exp_out.last) begin
                    report_mismatch($sformatf("ctrl_out %h last %b, expected %h last %b",
                                              ctrl_out.data, ctrl_out.last,
                                              exp_out.data, exp_out.last));
                end
            end
            if (cycle == resp_due) begin
                lookup_count++;
                if (exp_unknown) begin
                    $display("lookup hit a match entry whose action was never written");
                    err_count++;
                end else if (resp.valid !== 1'b1) begin
                    report_mismatch("resp.valid low when a response was due");
                end else if (resp.action !== exp_action || resp.phv !== exp_phv) begin
                    report_mismatch($sformatf("resp action %h phv %h, expected %h phv %h",
                                              resp.action, resp.phv, exp_action, exp_phv));
                end
            end else if (resp.valid !== 1'b0) begin
                report_mismatch("resp.valid high when no response was due");
            end
        end
    end

endmodule

// File: dv/lookup_checker.sv
`timescale 1ns/10ps

module lookup_checker import lookup_pkg::*; (
    input logic         clk,
    input logic         rst_n,
    input lookup_req_t  req,
    input lookup_resp_t resp,
    input ctrl_beat_t   ctrl_out,
    input logic         cam_we,
    input logic         act_hi_we,
    input logic         act_we
);

    int fail_count = 0;

    resp_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        resp.valid |=> !resp.valid)
    else begin
        $error("resp.valid stayed high for a second cycle");
        fail_count++;
    end

    // miss answers after 2 cycles, hit after 4
    resp_latency: assert property (@(posedge clk) disable iff (!rst_n)
        resp.valid |-> ($past(req.valid, 2) || $past(req.valid, 4)))
    else begin
        $error("resp.valid did not follow key_valid by 2 or 4 cycles");
        fail_count++;
    end

    quiet_while_writing: assert property (@(posedge clk) disable iff (!rst_n)
        (cam_we || act_hi_we || act_we) |=> !ctrl_out.valid)
    else begin
        $error("ctrl_out.valid high while a table entry was being written");
        fail_count++;
    end

    one_table_at_a_time: assert property (@(posedge clk) disable iff (!rst_n)
        !(cam_we && act_we))
    else begin
        $error("cam_we and act_we high in the same cycle");
        fail_count++;
    end

endmodule

// File: logic/lookup_engine.sv
`timescale 1ns/10ps
`include "lookup_consts.svh"

module lookup_engine import lookup_pkg::*; #(
    parameter logic [4:0] stage_id  = 5'd0,
    parameter logic [2:0] lookup_id = 3'd2
) (
    input  logic         clk,
    input  logic         rst_n,
    input  lookup_req_t  req,
    output lookup_resp_t resp,
    input  ctrl_beat_t   ctrl_in,
    output ctrl_beat_t   ctrl_out
);

    logic load;
    idx_t start_idx;
    logic cam_step;
    logic act_step;
    logic cam_we;
    logic act_hi_we;
    logic act_we;
    idx_t cam_idx;
    idx_t act_idx;
    logic match;
    idx_t match_idx;
    logic rd_en;
    act_t rd_action;

    ctrl_parser #(
        .stage_id  (stage_id),
        .lookup_id (lookup_id)
    ) u_ctrl_parser (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl_in   (ctrl_in),
        .ctrl_out  (ctrl_out),
        .load      (load),
        .start_idx (start_idx),
        .cam_step  (cam_step),
        .act_step  (act_step),
        .cam_we    (cam_we),
        .act_hi_we (act_hi_we),
        .act_we    (act_we)
    );

    entry_index_counter u_index (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .start_idx (start_idx),
        .cam_step  (cam_step),
        .act_step  (act_step),
        .cam_idx   (cam_idx),
        .act_idx   (act_idx)
    );

    // entry beat carries the key in its low bits
    tcam_array u_tcam (
        .clk       (clk),
        .rst_n     (rst_n),
        .we        (cam_we),
        .wr_idx    (cam_idx),
        .wr_key    (ctrl_in.data[`LKP_KEY_W-1:0]),
        .key       (req.key),
        .mask      (req.mask),
        .lookup    (req.valid),
        .match     (match),
        .match_idx (match_idx)
    );

    action_table u_actions (
        .clk       (clk),
        .hi_we     (act_hi_we),
        .we        (act_we),
        .wr_data   (ctrl_in.data),
        .wr_idx    (act_idx),
        .rd_en     (rd_en),
        .rd_idx    (match_idx),
        .rd_action (rd_action)
    );

    lookup_sequencer u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .match     (match),
        .rd_action (rd_action),
        .rd_en     (rd_en),
        .resp      (resp)
    );

endmodule

// File: logic/lookup_sequencer.sv
`timescale 1ns/10ps
`include "lookup_consts.svh"

module lookup_sequencer import lookup_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  lookup_req_t  req,
    input  logic         match,
    input  act_t         rd_action,
    output logic         rd_en,
    output lookup_resp_t resp
);

    lookup_state_t state;
    phv_t          phv_hold;
    act_t          resp_action;
    phv_t          resp_phv;
    logic          resp_valid;
    logic          miss;

    assign miss  = (state == SEQ_WAIT_MATCH) && !match;
    assign rd_en = (state == SEQ_WAIT_READ);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= SEQ_IDLE;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    // requests outside idle are dropped
                    if (req.valid) begin
                        state <= SEQ_WAIT_MATCH;
                    end
                end
                SEQ_WAIT_MATCH: begin
                    if (match) begin
                        state <= SEQ_WAIT_READ;
                    end else begin
                        resp_valid <= 1'b1;
                        state      <= SEQ_IDLE;
                    end
                end
                SEQ_WAIT_READ: begin
                    state <= SEQ_SEND;
                end
                SEQ_SEND: begin
                    resp_valid <= 1'b1;
                    state      <= SEQ_IDLE;
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == SEQ_IDLE && req.valid) begin
            phv_hold <= req.phv;
        end
        if (miss) begin
            resp_action <= act_t'(`LKP_DEFAULT_ACT);
            resp_phv    <= phv_hold;
        end else if (state == SEQ_SEND) begin
            resp_action <= rd_action;
            resp_phv    <= phv_hold;
        end
    end

    assign resp.action = resp_action;
    assign resp.phv    = resp_phv;
    assign resp.valid  = resp_valid;

endmodule

// File: logic/action_table.sv
`timescale 1ns/10ps
`include "lookup_consts.svh"

module action_table import lookup_pkg::*; (
    input  logic       clk,
    input  logic       hi_we,
    input  logic       we,
    input  ctrl_data_t wr_data,
    input  idx_t       wr_idx,
    input  logic       rd_en,
    input  idx_t       rd_idx,
    output act_t       rd_action
);

    act_t       mem [`LKP_DEPTH];
    ctrl_data_t hi_half;

    // first beat of an entry is the upper half
    always_ff @(posedge clk) begin
        if (hi_we) begin
            hi_half <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_idx] <= {hi_half, wr_data};
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_action <= mem[rd_idx];
        end
    end

endmodule

// File: logic/tcam_array.sv
`timescale 1ns/10ps
`include "lookup_consts.svh"

module tcam_array import lookup_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic we,
    input  idx_t wr_idx,
    input  key_t wr_key,
    input  key_t key,
    input  key_t mask,
    input  logic lookup,
    output logic match,
    output idx_t match_idx
);

    key_t                  entry_key [`LKP_DEPTH];
    logic [`LKP_DEPTH-1:0] entry_valid;
    logic                  hit_any;
    idx_t                  hit_idx;

    always_ff @(posedge clk) begin
        if (we) begin
            entry_key[wr_idx] <= wr_key;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else if (we) begin
            entry_valid[wr_idx] <= 1'b1;
        end
    end

    // mask bit set means don't care; scan downward so the lowest index wins
    always_comb begin
        hit_any = 1'b0;
        hit_idx = '0;
        for (int i = `LKP_DEPTH - 1; i >= 0; i--) begin
            if (entry_valid[i] && (((entry_key[i] ^ key) & ~mask) == '0)) begin
                hit_any = 1'b1;
                hit_idx = idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            match     <= 1'b0;
            match_idx <= '0;
        end else if (lookup) begin
            match     <= hit_any;
            match_idx <= hit_idx;
        end
    end

endmodule

// File: logic/entry_index_counter.sv
`timescale 1ns/10ps

module entry_index_counter import lookup_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic load,
    input  idx_t start_idx,
    input  logic cam_step,
    input  logic act_step,
    output idx_t cam_idx,
    output idx_t act_idx
);

    // both indices start at the header index, wrap at table depth
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cam_idx <= '0;
            act_idx <= '0;
        end else if (load) begin
            cam_idx <= start_idx;
            act_idx <= start_idx;
        end else begin
            if (cam_step) begin
                cam_idx <= cam_idx + 1'b1;
            end
            if (act_step) begin
                act_idx <= act_idx + 1'b1;
            end
        end
    end

endmodule

// File: logic/ctrl_parser.sv
`timescale 1ns/10ps
`include "lookup_consts.svh"

module ctrl_parser import lookup_pkg::*; #(
    parameter logic [4:0] stage_id  = 5'd0,
    parameter logic [2:0] lookup_id = 3'd2
) (
    input  logic       clk,
    input  logic       rst_n,
    input  ctrl_beat_t ctrl_in,
    output ctrl_beat_t ctrl_out,
    output logic       load,
    output idx_t       start_idx,
    output logic       cam_step,
    output logic       act_step,
    output logic       cam_we,
    output logic       act_hi_we,
    output logic       act_we
);

    ctrl_state_t state;
    logic [15:0] hdr_flag;
    logic [7:0]  hdr_mod;
    logic [3:0]  hdr_sel;
    logic        addressed;
    logic        hdr_beat;
    ctrl_data_t  out_data;
    logic        out_valid;
    logic        out_last;

    // header fields, only meaningful on the first beat
    assign hdr_flag  = ctrl_in.data[`LKP_FLAG_LSB +: 16];
    assign hdr_mod   = ctrl_in.data[`LKP_MODID_LSB +: 8];
    assign hdr_sel   = ctrl_in.data[`LKP_SEL_LSB +: 4];
    assign start_idx = ctrl_in.data[`LKP_START_LSB +: `LKP_IDX_W];

    assign addressed = (hdr_mod[7:3] == stage_id) && (hdr_mod[2:0] == lookup_id)
                       && (hdr_flag == `LKP_MAGIC);
    assign hdr_beat  = (state == CTRL_IDLE) && ctrl_in.valid;

    assign load      = hdr_beat && addressed;
    assign cam_we    = (state == CTRL_CAM_ENTRY) && ctrl_in.valid;
    assign cam_step  = cam_we;
    assign act_hi_we = (state == CTRL_ACT_HI) && ctrl_in.valid;
    assign act_we    = (state == CTRL_ACT_LO) && ctrl_in.valid;
    assign act_step  = act_we;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= CTRL_IDLE;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            case (state)
                CTRL_IDLE: begin
                    if (ctrl_in.valid && addressed) begin
                        // a header with no body writes nothing
                        if (!ctrl_in.last) begin
                            state <= (hdr_sel == 4'd0) ? CTRL_CAM_ENTRY : CTRL_ACT_HI;
                        end
                    end else if (ctrl_in.valid) begin
                        out_valid <= 1'b1;
                        out_last  <= ctrl_in.last;
                        if (!ctrl_in.last) begin
                            state <= CTRL_PASS;
                        end
                    end
                end
                CTRL_PASS: begin
                    out_valid <= ctrl_in.valid;
                    out_last  <= ctrl_in.last;
                    if (ctrl_in.valid && ctrl_in.last) begin
                        state <= CTRL_IDLE;
                    end
                end
                CTRL_CAM_ENTRY: begin
                    if (ctrl_in.valid && ctrl_in.last) begin
                        state <= CTRL_IDLE;
                    end
                end
                CTRL_ACT_HI: begin
                    // a dangling upper half is dropped
                    if (ctrl_in.valid) begin
                        state <= ctrl_in.last ? CTRL_IDLE : CTRL_ACT_LO;
                    end
                end
                CTRL_ACT_LO: begin
                    if (ctrl_in.valid) begin
                        state <= ctrl_in.last ? CTRL_IDLE : CTRL_ACT_HI;
                    end
                end
                default: begin
                    state <= CTRL_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        out_data <= ctrl_in.data;
    end

    assign ctrl_out.data  = out_data;
    assign ctrl_out.valid = out_valid;
    assign ctrl_out.last  = out_last;

endmodule

// File: logic/lookup_pkg.sv
`include "lookup_consts.svh"

package lookup_pkg;

    typedef logic [`LKP_KEY_W-1:0]  key_t;
    typedef logic [`LKP_ACT_W-1:0]  act_t;
    typedef logic [`LKP_PHV_W-1:0]  phv_t;
    typedef logic [`LKP_CTRL_W-1:0] ctrl_data_t;
    typedef logic [`LKP_IDX_W-1:0]  idx_t;

    // one beat of the control stream
    typedef struct packed {
        ctrl_data_t data;
        logic       valid;
        logic       last;
    } ctrl_beat_t;

    typedef struct packed {
        key_t key;
        key_t mask;
        phv_t phv;
        logic valid;
    } lookup_req_t;

    typedef struct packed {
        act_t action;
        phv_t phv;
        logic valid;
    } lookup_resp_t;

    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_PASS,
        CTRL_CAM_ENTRY,
        CTRL_ACT_HI,
        CTRL_ACT_LO
    } ctrl_state_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_WAIT_MATCH,
        SEQ_WAIT_READ,
        SEQ_SEND
    } lookup_state_t;

endpackage

// File: logic/lookup_consts.svh
`ifndef LOOKUP_CONSTS_SVH
`define LOOKUP_CONSTS_SVH

// datapath widths
`define LKP_KEY_W       32
`define LKP_ACT_W       128
`define LKP_PHV_W       64
`define LKP_CTRL_W      64

// table geometry
`define LKP_DEPTH       16
`define LKP_IDX_W       4

`define LKP_MAGIC       16'hf1f2
`define LKP_DEFAULT_ACT 'h3f

// header beat field positions (lsb of each field)
`define LKP_FLAG_LSB    48
`define LKP_MODID_LSB   40
`define LKP_SEL_LSB     36
`define LKP_START_LSB   28

`endif
